// ==== compile.f ====
source/matmul_pkg.sv
source/row_stream_if.sv
source/matrix_bank.sv
source/operand_fetch.sv
source/mac_cell.sv
source/systolic_array.sv
source/result_writeback.sv
source/matmul_top.sv
tb/matmul_sva.sv
tb/matmul_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vmatmul_tb

$(SIM): compile.f $(wildcard source/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module matmul_tb -Mdir obj_dir -f compile.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tb/matmul_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_tb
  import matmul_pkg::*;
();

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 200;

  logic              clk_mem;
  logic              reset;
  logic              start;
  logic              we_a;
  logic              we_b;
  logic              read_enable;
  logic [ADDR_W-1:0] host_addr;
  row_word_t         host_data;
  row_word_t         result_data;
  logic              busy;
  logic              done;

  // Reference matrices, indexed [row][column]
  logic [DATA_W-1:0] mat_a [MAT_N][MAT_N];
  logic [DATA_W-1:0] mat_b [MAT_N][MAT_N];

  logic              chk_req;
  row_word_t         chk_row;
  logic              exp_valid_q0;
  logic              exp_valid_q1;
  row_word_t         exp_row_q0;
  row_word_t         exp_row_q1;

  string             test_name;
  int                mismatch_count = 0;
  int                protocol_count;

  matmul_top #(.N(MAT_N)) dut0 (
    .clk_mem     (clk_mem),
    .reset       (reset),
    .start       (start),
    .we_a        (we_a),
    .we_b        (we_b),
    .read_enable (read_enable),
    .host_addr   (host_addr),
    .host_data   (host_data),
    .result_data (result_data),
    .busy        (busy),
    .done        (done)
  );

  initial begin
    clk_mem = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_mem = ~clk_mem;
    end
  end

  //////////////////////////////////////////////////
  // Read-back checking
  //////////////////////////////////////////////////

  // Expected rows wait two edges for the bank latency
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      exp_valid_q0 <= 1'b0;
      exp_valid_q1 <= 1'b0;
      exp_row_q0   <= '0;
      exp_row_q1   <= '0;
    end else begin
      exp_valid_q0 <= chk_req;
      exp_row_q0   <= chk_row;
      exp_valid_q1 <= exp_valid_q0;
      exp_row_q1   <= exp_row_q0;
    end
  end

  read_matches: assert property (@(posedge clk_mem) disable iff (reset)
    exp_valid_q1 |-> (result_data == exp_row_q1))
  else begin
    mismatch_count = mismatch_count + 1;
    $display("MISMATCH %s: expected %h, actual %h",
             test_name, $sampled(exp_row_q1), $sampled(result_data));
  end

  // C[i][j] is the sum over k of A[i][k] * B[k][j], modulo 256
  function automatic row_word_t expected_row(input int i);
    row_word_t row;
    int        sum;
    row = '0;
    for (int j = 0; j < MAT_N; j++) begin
      sum = 0;
      for (int k = 0; k < MAT_N; k++) begin
        sum = sum + int'(mat_a[i][k]) * int'(mat_b[k][j]);
      end
      row[j] = DATA_W'(sum % 256);
    end
    return row;
  endfunction

  //////////////////////////////////////////////////
  // Host side tasks
  //////////////////////////////////////////////////

  task automatic randomize_matrices(input bit new_a, input int lo, input int hi);
    for (int i = 0; i < MAT_N; i++) begin
      for (int j = 0; j < MAT_N; j++) begin
        if (new_a) begin
          mat_a[i][j] = DATA_W'($urandom_range(hi, lo));
        end
        mat_b[i][j] = DATA_W'($urandom_range(hi, lo));
      end
    end
  endtask

  // Bank A word k is column k of A
  task automatic load_a();
    for (int k = 0; k < MAT_N; k++) begin
      host_addr = ADDR_W'(k);
      for (int i = 0; i < MAT_N; i++) begin
        host_data[i] = mat_a[i][k];
      end
      we_a = 1'b1;
      @(negedge clk_mem);
    end
    we_a = 1'b0;
  endtask

  // Bank B word k is row k of B
  task automatic load_b();
    for (int k = 0; k < MAT_N; k++) begin
      host_addr = ADDR_W'(k);
      for (int j = 0; j < MAT_N; j++) begin
        host_data[j] = mat_b[k][j];
      end
      we_b = 1'b1;
      @(negedge clk_mem);
    end
    we_b = 1'b0;
  endtask

  task automatic start_engine();
    start = 1'b1;
    @(negedge clk_mem);
    start = 1'b0;
  endtask

  task automatic wait_for_done();
    do begin
      @(negedge clk_mem);
    end while (!done);
  endtask

  task automatic read_back();
    for (int i = 0; i < MAT_N; i++) begin
      read_enable = 1'b1;
      host_addr   = ADDR_W'(i);
      chk_req     = 1'b1;
      chk_row     = expected_row(i);
      @(negedge clk_mem);
    end
    read_enable = 1'b0;
    chk_req     = 1'b0;
    // Last reads still in the bank pipeline
    repeat (3) @(negedge clk_mem);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(82));
    reset       = 1'b1;
    start       = 1'b0;
    we_a        = 1'b0;
    we_b        = 1'b0;
    read_enable = 1'b0;
    host_addr   = '0;
    host_data   = '0;
    chk_req     = 1'b0;
    chk_row     = '0;
    test_name   = "reset";
    repeat (5) @(negedge clk_mem);
    reset = 1'b0;
    @(negedge clk_mem);

    test_name = "identity";
    for (int i = 0; i < MAT_N; i++) begin
      for (int j = 0; j < MAT_N; j++) begin
        mat_a[i][j] = (i == j) ? 8'd1 : 8'd0;
      end
    end
    randomize_matrices(1'b0, 0, 255);
    load_a();
    load_b();
    start_engine();
    wait_for_done();
    read_back();

    test_name = "wraparound";
    randomize_matrices(1'b1, 128, 255);
    load_a();
    load_b();
    start_engine();
    wait_for_done();
    read_back();

    // Host reads steal the C port while the engine runs
    test_name = "back_pressure";
    randomize_matrices(1'b1, 0, 255);
    load_a();
    load_b();
    start_engine();
    while (!done) begin
      read_enable = 1'($urandom_range(1, 0));
      host_addr   = ADDR_W'($urandom_range(MAT_N - 1, 0));
      @(negedge clk_mem);
    end
    read_enable = 1'b0;
    read_back();

    test_name = "protocol";
    randomize_matrices(1'b1, 0, 255);
    load_a();
    load_b();
    start_engine();
    @(negedge clk_mem);
    start_engine();
    for (int k = 0; k < MAT_N; k++) begin
      host_addr = ADDR_W'(k);
      host_data = row_word_t'($urandom());
      we_a      = 1'b1;
      we_b      = 1'b1;
      @(negedge clk_mem);
    end
    we_a = 1'b0;
    we_b = 1'b0;
    wait_for_done();
    // Quiet gap, a stray done would show up here
    repeat (40) @(negedge clk_mem);
    read_back();

    // A stays from the previous test
    test_name = "back_to_back";
    randomize_matrices(1'b0, 0, 255);
    load_b();
    start_engine();
    wait_for_done();
    read_back();
    randomize_matrices(1'b0, 0, 255);
    load_b();
    start_engine();
    wait_for_done();
    read_back();

    protocol_count = dut0.sva0.violations;
    $display("errors: read mismatches %0d, protocol violations %0d",
             mismatch_count, protocol_count);
    if ((mismatch_count == 0) && (protocol_count == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/matmul_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_sva
  import matmul_pkg::*;
(
  input  logic          clk_mem,
  input  logic          reset,
  input  logic          start,
  input  logic          busy,
  input  logic          done,
  input  row_word_t     result_data,
  input  logic          op_valid,
  input  logic          op_ready,
  input  logic          res_valid,
  input  logic          res_ready,
  input  logic          res_last,
  input  result_row_t   res_payload
);

  int   violations = 0;
  logic armed;

  // Set by an accepted start, cleared by its done
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      armed <= 1'b0;
    end else if (start && !busy) begin
      armed <= 1'b1;
    end else if (done) begin
      armed <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Reset and completion
  //////////////////////////////////////////////////

  idle_after_reset: assert property (@(posedge clk_mem)
    reset |=> (!done && !busy && (result_data == '0) && !op_valid && !res_valid && !op_ready))
  else begin
    violations = violations + 1;
    $error("engine outputs not idle after reset");
  end

  done_single_cycle: assert property (@(posedge clk_mem) disable iff (reset)
    done |=> !done)
  else begin
    violations = violations + 1;
    $error("done stayed high for more than one cycle");
  end

  busy_falls_with_done: assert property (@(posedge clk_mem) disable iff (reset)
    done |-> $fell(busy))
  else begin
    violations = violations + 1;
    $error("done pulsed without busy falling in the same cycle");
  end

  busy_only_falls_on_done: assert property (@(posedge clk_mem) disable iff (reset)
    $fell(busy) |-> done)
  else begin
    violations = violations + 1;
    $error("busy fell without a done pulse");
  end

  done_needs_start: assert property (@(posedge clk_mem) disable iff (reset)
    done |-> armed)
  else begin
    violations = violations + 1;
    $error("done arrived with no accepted start since the previous done");
  end

  //////////////////////////////////////////////////
  // Stream handshakes
  //////////////////////////////////////////////////

  result_hold: assert property (@(posedge clk_mem) disable iff (reset)
    (res_valid && !res_ready) |=> (res_valid && $stable(res_payload) && $stable(res_last)))
  else begin
    violations = violations + 1;
    $error("result stream changed before its transfer");
  end

endmodule

bind matmul_top matmul_sva sva0 (
  .clk_mem     (clk_mem),
  .reset       (reset),
  .start       (start),
  .busy        (busy),
  .done        (done),
  .result_data (result_data),
  .op_valid    (operand_stream.valid),
  .op_ready    (operand_stream.ready),
  .res_valid   (result_stream.valid),
  .res_ready   (result_stream.ready),
  .res_last    (result_stream.last),
  .res_payload (result_stream.payload)
);

`default_nettype wire

// ==== source/matmul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_top
  import matmul_pkg::*;
#(
  parameter int N = MAT_N
) (
  input  logic              clk_mem,
  input  logic              reset,
  input  logic              start,
  input  logic              we_a,
  input  logic              we_b,
  input  logic              read_enable,
  input  logic [ADDR_W-1:0] host_addr,
  input  row_word_t         host_data,
  output row_word_t         result_data,
  output logic              busy,
  output logic              done
);

  logic [ADDR_W-1:0] a_addr;
  logic [ADDR_W-1:0] b_addr;
  logic [ADDR_W-1:0] c_addr;
  row_word_t         a_rdata;
  row_word_t         b_rdata;
  row_word_t         c_wdata;
  logic              c_we;

  row_stream_if #(.payload_t(operand_pair_t)) operand_stream ();
  row_stream_if #(.payload_t(result_row_t))   result_stream ();

  //////////////////////////////////////////////////
  // Operand and result banks
  //////////////////////////////////////////////////

  // Host writes only land while idle
  matrix_bank #(.DEPTH(N)) bank_a (
    .clk_mem (clk_mem),
    .reset   (reset),
    .addr    (a_addr),
    .wdata   (host_data),
    .we      (we_a && !busy),
    .rdata   (a_rdata)
  );

  matrix_bank #(.DEPTH(N)) bank_b (
    .clk_mem (clk_mem),
    .reset   (reset),
    .addr    (b_addr),
    .wdata   (host_data),
    .we      (we_b && !busy),
    .rdata   (b_rdata)
  );

  matrix_bank #(.DEPTH(N)) bank_c (
    .clk_mem (clk_mem),
    .reset   (reset),
    .addr    (c_addr),
    .wdata   (c_wdata),
    .we      (c_we),
    .rdata   (result_data)
  );

  //////////////////////////////////////////////////
  // Fetch, array and writeback
  //////////////////////////////////////////////////

  operand_fetch #(.N(N)) u_fetch (
    .clk_mem        (clk_mem),
    .reset          (reset),
    .start          (start),
    .busy           (busy),
    .host_addr      (host_addr),
    .a_addr         (a_addr),
    .b_addr         (b_addr),
    .a_rdata        (a_rdata),
    .b_rdata        (b_rdata),
    .operand_stream (operand_stream.source)
  );

  systolic_array #(.N(N)) u_array (
    .clk_mem        (clk_mem),
    .reset          (reset),
    .operand_stream (operand_stream.sink),
    .result_stream  (result_stream.source)
  );

  result_writeback #(.N(N)) u_writeback (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start         (start),
    .read_enable   (read_enable),
    .host_addr     (host_addr),
    .result_stream (result_stream.sink),
    .c_addr        (c_addr),
    .c_wdata       (c_wdata),
    .c_we          (c_we),
    .done          (done),
    .busy          (busy)
  );

endmodule

`default_nettype wire

// ==== source/result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writeback
  import matmul_pkg::*;
#(
  parameter int N = MAT_N
) (
  input  logic              clk_mem,
  input  logic              reset,
  input  logic              start,
  input  logic              read_enable,
  input  logic [ADDR_W-1:0] host_addr,
  row_stream_if.sink        result_stream,
  output logic [ADDR_W-1:0] c_addr,
  output row_word_t         c_wdata,
  output logic              c_we,
  output logic              done,
  output logic              busy
);

  result_row_t       res;
  logic              res_xfer;
  logic [ADDR_W-1:0] rd_addr_q;

  assign res = result_stream.payload;

  // Host reads win the C port
  assign result_stream.ready = !read_enable;
  assign res_xfer            = result_stream.valid && result_stream.ready;

  // Between accesses the port stays on the last host row
  always_comb begin
    c_we    = res_xfer;
    c_wdata = res.c_row;
    if (read_enable) begin
      c_addr = host_addr;
    end else if (res_xfer) begin
      c_addr = res.row;
    end else begin
      c_addr = rd_addr_q;
    end
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rd_addr_q <= ADDR_W'(N - 1);
      done      <= 1'b0;
      busy      <= 1'b0;
    end else begin
      done <= res_xfer && result_stream.last;
      if (read_enable) begin
        rd_addr_q <= host_addr;
      end
      if (res_xfer && result_stream.last) begin
        busy <= 1'b0;
      end else if (start) begin
        busy <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/systolic_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_array
  import matmul_pkg::*;
#(
  parameter int N = MAT_N
) (
  input  logic         clk_mem,
  input  logic         reset,
  row_stream_if.sink   operand_stream,
  row_stream_if.source result_stream
);

  operand_pair_t     op;
  result_row_t       res;
  row_word_t         res_word;
  logic              op_xfer;
  logic              res_xfer;
  logic              drain_fire;

  // Step markers, indexed by distance from cell (0,0)
  logic [N-1:0]      vld_sr;
  logic [2*N-2:0]    first_sr;
  logic [2*N-1:0]    last_sr;

  logic [DATA_W-1:0] a_h [N][N+1];
  logic [DATA_W-1:0] b_v [N+1][N];
  logic              v_h [N][N+1];
  logic [ACC_W-1:0]  acc [N][N];

  logic              pend;
  logic              pend_d;
  logic              drain_active;
  logic              drain_d;
  logic [ADDR_W-1:0] drain_row;
  logic [ADDR_W-1:0] row_d;
  logic              op_ready;

  assign op       = operand_stream.payload;
  assign op_xfer  = operand_stream.valid && operand_stream.ready;
  assign res_xfer = result_stream.valid && result_stream.ready;

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      vld_sr   <= '0;
      first_sr <= '0;
      last_sr  <= '0;
    end else begin
      vld_sr   <= {vld_sr[N-2:0], op_xfer};
      first_sr <= {first_sr[2*N-3:0], op_xfer && (op.k == '0)};
      last_sr  <= {last_sr[2*N-2:0], op_xfer && operand_stream.last};
    end
  end

  //////////////////////////////////////////////////
  // Input skew, row i and column i wait i cycles
  //////////////////////////////////////////////////

  for (genvar i = 0; i < N; i++) begin : g_skew
    logic [DATA_W-1:0] a_sr [i+1];
    logic [DATA_W-1:0] b_sr [i+1];

    always_ff @(posedge clk_mem) begin
      a_sr[0] <= op.a_col[i];
      b_sr[0] <= op.b_row[i];
      for (int s = 1; s <= i; s++) begin
        a_sr[s] <= a_sr[s-1];
        b_sr[s] <= b_sr[s-1];
      end
    end

    assign a_h[i][0] = a_sr[i];
    assign v_h[i][0] = vld_sr[i];
    assign b_v[0][i] = b_sr[i];
  end

  //////////////////////////////////////////////////
  // Cell grid
  //////////////////////////////////////////////////

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      mac_cell u_cell (
        .clk_mem    (clk_mem),
        .reset      (reset),
        .a_in       (a_h[i][j]),
        .b_in       (b_v[i][j]),
        .step_valid (v_h[i][j]),
        .first      (first_sr[i+j]),
        .a_out      (a_h[i][j+1]),
        .b_out      (b_v[i+1][j]),
        .valid_out  (v_h[i][j+1]),
        .acc        (acc[i][j])
      );
    end
  end

  //////////////////////////////////////////////////
  // Result drain
  //////////////////////////////////////////////////

  // Last step has left the bottom right cell
  assign drain_fire = v_h[N-1][N] && last_sr[2*N-1];

  always_comb begin
    pend_d  = pend;
    drain_d = drain_active;
    row_d   = drain_row;
    if (op_xfer && operand_stream.last) begin
      pend_d = 1'b1;
    end
    if (drain_fire) begin
      pend_d  = 1'b0;
      drain_d = 1'b1;
      row_d   = '0;
    end else if (res_xfer) begin
      if (result_stream.last) begin
        drain_d = 1'b0;
      end else begin
        row_d = drain_row + 1'b1;
      end
    end
  end

  // No new operands until the last row has left
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      pend         <= 1'b0;
      drain_active <= 1'b0;
      drain_row    <= '0;
      op_ready     <= 1'b0;
    end else begin
      pend         <= pend_d;
      drain_active <= drain_d;
      drain_row    <= row_d;
      op_ready     <= !(pend_d || drain_d);
    end
  end

  always_comb begin
    res_word = '0;
    for (int j = 0; j < N; j++) begin
      res_word[j] = acc[drain_row][j];
    end
  end

  assign res.c_row = res_word;
  assign res.row   = drain_row;

  assign operand_stream.ready  = op_ready;
  assign result_stream.valid   = drain_active;
  assign result_stream.payload = res;
  assign result_stream.last    = (drain_row == ADDR_W'(N - 1));

endmodule

`default_nettype wire

// ==== source/mac_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_cell
  import matmul_pkg::*;
(
  input  logic              clk_mem,
  input  logic              reset,
  input  logic [DATA_W-1:0] a_in,
  input  logic [DATA_W-1:0] b_in,
  input  logic              step_valid,
  input  logic              first,
  output logic [DATA_W-1:0] a_out,
  output logic [DATA_W-1:0] b_out,
  output logic              valid_out,
  output logic [ACC_W-1:0]  acc
);

  logic [ACC_W-1:0] prod;

  // Product truncated to the accumulator width
  assign prod = ACC_W'(a_in) * ACC_W'(b_in);

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= step_valid;
    end
  end

  // Operands move on to the right and lower neighbours
  always_ff @(posedge clk_mem) begin
    a_out <= a_in;
    b_out <= b_in;
    if (step_valid) begin
      // k = 0 starts a new dot product
      acc <= first ? prod : acc + prod;
    end
  end

endmodule

`default_nettype wire

// ==== source/operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch
  import matmul_pkg::*;
#(
  parameter int N = MAT_N
) (
  input  logic              clk_mem,
  input  logic              reset,
  input  logic              start,
  input  logic              busy,
  input  logic [ADDR_W-1:0] host_addr,
  output logic [ADDR_W-1:0] a_addr,
  output logic [ADDR_W-1:0] b_addr,
  input  row_word_t         a_rdata,
  input  row_word_t         b_rdata,
  row_stream_if.source      operand_stream
);

  logic              issuing;
  logic              issue;
  logic [ADDR_W-1:0] rd_cnt;
  logic              v1;
  logic              v2;
  logic [ADDR_W-1:0] k1;
  logic [ADDR_W-1:0] k2;
  logic              push;
  logic              pop;
  logic [1:0]        cnt;
  logic [1:0]        in_use;
  operand_pair_t     in_pair;
  operand_pair_t     q0;
  operand_pair_t     q1;

  // Host owns the bank ports while idle
  assign a_addr = busy ? rd_cnt : host_addr;
  assign b_addr = busy ? rd_cnt : host_addr;

  // Reads in flight plus queued words never exceed the two slots
  assign push   = v2;
  assign pop    = operand_stream.valid && operand_stream.ready;
  assign in_use = cnt + {1'b0, v1} + {1'b0, v2};
  assign issue  = issuing && ((in_use < 2'd2) || pop);

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      issuing <= 1'b0;
      rd_cnt  <= '0;
      v1      <= 1'b0;
      v2      <= 1'b0;
      cnt     <= '0;
    end else begin
      v1  <= issue;
      v2  <= v1;
      cnt <= cnt + 2'(push) - 2'(pop);
      if (start && !busy) begin
        issuing <= 1'b1;
        rd_cnt  <= '0;
      end else if (issue) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == ADDR_W'(N - 1)) begin
          issuing <= 1'b0;
        end
      end
    end
  end

  // Step tag follows the two-cycle bank latency
  always_ff @(posedge clk_mem) begin
    k1 <= rd_cnt;
    k2 <= k1;
  end

  assign in_pair.a_col = a_rdata;
  assign in_pair.b_row = b_rdata;
  assign in_pair.k     = k2;

  //////////////////////////////////////////////////
  // Two-entry skid queue, q0 is the head
  //////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (push && ((cnt == 2'd0) || ((cnt == 2'd1) && pop))) begin
      q0 <= in_pair;
    end else if (pop) begin
      q0 <= q1;
    end
    if (push) begin
      q1 <= in_pair;
    end
  end

  assign operand_stream.valid   = (cnt != 2'd0);
  assign operand_stream.payload = q0;
  assign operand_stream.last    = (q0.k == ADDR_W'(N - 1));

endmodule

`default_nettype wire

// ==== source/matrix_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_bank
  import matmul_pkg::*;
#(
  parameter int DEPTH = MAT_N
) (
  input  logic              clk_mem,
  input  logic              reset,
  input  logic [ADDR_W-1:0] addr,
  input  row_word_t         wdata,
  input  logic              we,
  output row_word_t         rdata
);

  row_word_t         mem [DEPTH];
  logic [ADDR_W-1:0] addr_q;
  row_word_t         wdata_q;
  logic              we_q;

  // Address stage, parks at the top word
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      addr_q <= ADDR_W'(DEPTH - 1);
      we_q   <= 1'b0;
    end else begin
      addr_q <= addr;
      we_q   <= we;
    end
  end

  always_ff @(posedge clk_mem) begin
    wdata_q <= wdata;
    if (we_q) begin
      mem[addr_q] <= wdata_q;
    end
  end

  // Output register keeps its word during a write cycle
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rdata <= '0;
    end else if (!we_q) begin
      rdata <= mem[addr_q];
    end
  end

endmodule

`default_nettype wire

// ==== source/row_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Valid/ready stream, one payload word per transfer
interface row_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  logic     last;
  payload_t payload;

  modport source (
    output valid,
    output last,
    output payload,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// ==== source/matmul_pkg.sv ====
`default_nettype none

package matmul_pkg;

  //////////////////////////////////////////////////
  // Engine sizes
  //////////////////////////////////////////////////

  localparam int MAT_N  = 4;
  localparam int DATA_W = 8;
  localparam int ADDR_W = 2;

  // Results wrap at the element width
  localparam int ACC_W  = DATA_W;

  //////////////////////////////////////////////////
  // Bank word and stream payloads
  //////////////////////////////////////////////////

  // Element 0 sits in the least significant byte
  typedef logic [MAT_N-1:0][DATA_W-1:0] row_word_t;

  // Column k of A with row k of B
  typedef struct packed {
    row_word_t         a_col;
    row_word_t         b_row;
    logic [ADDR_W-1:0] k;
  } operand_pair_t;

  // One finished row of C
  typedef struct packed {
    row_word_t         c_row;
    logic [ADDR_W-1:0] row;
  } result_row_t;

endpackage

`default_nettype wire
